// File: hdl/irq_pkg.sv
// Interrupt and sleep controller package: constants, CSR and retire structs, state enums
`default_nettype none

package irq_pkg;

  // --------------------------------------------------------------------
  // Constants
  // --------------------------------------------------------------------
  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines are 31..16, 11, 7 and 3
  localparam logic [31:0] VALID_IRQ_MASK = 32'hffff_0888;

  // Sleep instruction encodings seen at writeback
  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
  localparam logic [31:0] WFE_INSTR = 32'h8c00_0073;

  // Positions of MIE and MPIE inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // --------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------
  typedef logic [NUM_IRQ-1:0] irq_vec_t;
  typedef logic [4:0]         irq_id_t;

  // Only two CSRs are reachable through the write port
  typedef enum logic {
    CSR_MIE     = 1'b0,
    CSR_MSTATUS = 1'b1
  } csr_addr_e;

  typedef struct packed {
    logic        we;
    csr_addr_e   addr;
    logic [31:0] data;
  } csr_wr_t;

  // Writeback stage view of one retiring instruction
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        err;
    logic        killed;
  } retire_t;

  typedef struct packed {
    logic    ack;
    irq_id_t id;
  } irq_ack_t;

  typedef enum logic [1:0] {
    SLEEP_NONE = 2'd0,
    SLEEP_WFI  = 2'd1,
    SLEEP_WFE  = 2'd2
  } sleep_op_e;

  typedef enum logic [1:0] {
    ST_RUN   = 2'd0,
    ST_DRAIN = 2'd1,
    ST_SLEEP = 2'd2
  } sleep_state_e;

endpackage

`default_nettype wire

// File: hdl/irq_pending.sv
// Pending register sampling the external interrupt lines with reserved lines cleared
`timescale 1ns/10ps
`default_nettype none

module irq_pending (
  input  wire                clk_i,
  input  wire                rst_ni,
  // Raw external interrupt levels
  input  irq_pkg::irq_vec_t  irq_i,
  // Registered pending vector, mip
  output irq_pkg::irq_vec_t  mip_o
);

  // --------------------------------------------------------------------
  // Pending register
  // --------------------------------------------------------------------
  irq_pkg::irq_vec_t mip_q;
  irq_pkg::irq_vec_t irq_masked;

  // Lines that do not exist never reach the pending register
  assign irq_masked = irq_i & irq_pkg::irq_vec_t'(irq_pkg::VALID_IRQ_MASK);

  // One cycle of latency from irq_i to mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_masked;
    end
  end

  assign mip_o = mip_q;

endmodule

`default_nettype wire

// File: hdl/irq_csr.sv
// Interrupt CSR block: mie register and the mstatus MIE/MPIE bits
`timescale 1ns/10ps
`default_nettype none

module irq_csr (
  input  wire                clk_i,
  input  wire                rst_ni,
  // Software write port
  input  irq_pkg::csr_wr_t   csr_wr_i,
  // Return from trap, restores MIE from MPIE
  input  wire                mret_i,
  // Interrupt taken this cycle
  input  wire                take_i,
  output irq_pkg::irq_vec_t  mie_o,
  output wire                mstatus_mie_o
);

  // --------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------
  logic wr_mie;
  logic wr_mstatus;

  assign wr_mie     = csr_wr_i.we && (csr_wr_i.addr == irq_pkg::CSR_MIE);
  assign wr_mstatus = csr_wr_i.we && (csr_wr_i.addr == irq_pkg::CSR_MSTATUS);

  // --------------------------------------------------------------------
  // mie register
  // --------------------------------------------------------------------
  irq_pkg::irq_vec_t mie_q;

  // Reserved enable bits read back as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q <= '0;
    end else if (wr_mie) begin
      mie_q <= irq_pkg::irq_vec_t'(csr_wr_i.data & irq_pkg::VALID_IRQ_MASK);
    end
  end

  // --------------------------------------------------------------------
  // mstatus MIE and MPIE
  // --------------------------------------------------------------------
  logic mie_bit_q;
  logic mpie_bit_q;

  // Priority: take, then mret, then software write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_bit_q  <= 1'b0;
      mpie_bit_q <= 1'b0;
    end else if (take_i) begin
      // Save the enable and mask further interrupts
      mpie_bit_q <= mie_bit_q;
      mie_bit_q  <= 1'b0;
    end else if (mret_i) begin
      mie_bit_q  <= mpie_bit_q;
      mpie_bit_q <= 1'b1;
    end else if (wr_mstatus) begin
      mie_bit_q  <= csr_wr_i.data[irq_pkg::MSTATUS_MIE_BIT];
      mpie_bit_q <= csr_wr_i.data[irq_pkg::MSTATUS_MPIE_BIT];
    end
  end

  assign mie_o         = mie_q;
  assign mstatus_mie_o = mie_bit_q;

endmodule

`default_nettype wire

// File: hdl/irq_prio_arb.sv
// Fixed-priority interrupt arbiter with take strobe and registered acknowledge
`timescale 1ns/10ps
`default_nettype none

module irq_prio_arb (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  irq_pkg::irq_vec_t  mip_i,
  input  irq_pkg::irq_vec_t  mie_i,
  // mstatus.MIE
  input  wire                global_en_i,
  // Combinational, same cycle as the winner
  output wire                take_o,
  // Any enabled line pending, global enable ignored
  output wire                wake_pending_o,
  output irq_pkg::irq_ack_t  irq_ack_o
);

  // --------------------------------------------------------------------
  // Winner selection
  // --------------------------------------------------------------------
  irq_pkg::irq_vec_t pend_en;
  irq_pkg::irq_id_t  win_id;
  logic              win_valid;

  assign pend_en = mip_i & mie_i;

  // Lowest priority is checked first so later hits override it
  // Order from high to low: 31..16, 11, 3, 7
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = 5'd7;
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = 5'd3;
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = 5'd11;
    end
    for (int i = 16; i < irq_pkg::NUM_IRQ; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = irq_pkg::irq_id_t'(i);
      end
    end
  end

  assign take_o         = win_valid && global_en_i;
  assign wake_pending_o = |pend_en;

  // --------------------------------------------------------------------
  // Acknowledge register
  // --------------------------------------------------------------------
  irq_pkg::irq_ack_t ack_q;

  // Single-cycle pulse since MIE drops at the take edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= '0;
    end else begin
      ack_q.ack <= take_o;
      if (take_o) begin
        ack_q.id <= win_id;
      end
    end
  end

  assign irq_ack_o = ack_q;

endmodule

`default_nettype wire

// File: hdl/wfi_sleep_ctrl.sv
// Sleep controller: WFI/WFE decode at writeback and the run/drain/sleep FSM
`timescale 1ns/10ps
`default_nettype none

module wfi_sleep_ctrl #(
  parameter int unsigned OUTSTANDING_W = 2
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  irq_pkg::retire_t         retire_i,
  // Pipeline drain status
  input  wire [OUTSTANDING_W-1:0]  alignbuf_outstanding_i,
  input  wire                      lsu_busy_i,
  // Wake sources
  input  wire                      wake_pending_i,
  input  wire                      debug_req_i,
  input  wire                      wfe_event_i,
  output wire                      core_sleep_o
);

  // --------------------------------------------------------------------
  // Instruction decode
  // --------------------------------------------------------------------
  irq_pkg::sleep_op_e sleep_op;
  logic               retire_ok;

  // Faulted or flushed instructions do not count as retired
  assign retire_ok = retire_i.valid && !retire_i.err && !retire_i.killed;

  always_comb begin
    sleep_op = irq_pkg::SLEEP_NONE;
    if (retire_ok && (retire_i.rdata == irq_pkg::WFI_INSTR)) begin
      sleep_op = irq_pkg::SLEEP_WFI;
    end else if (retire_ok && (retire_i.rdata == irq_pkg::WFE_INSTR)) begin
      sleep_op = irq_pkg::SLEEP_WFE;
    end
  end

  // --------------------------------------------------------------------
  // Sleep FSM
  // --------------------------------------------------------------------
  irq_pkg::sleep_state_e state_q;
  irq_pkg::sleep_state_e state_d;
  logic                  is_wfe_q;
  logic                  wake;
  logic                  drained;

  // Event input only counts for WFE
  assign wake    = wake_pending_i || debug_req_i || (wfe_event_i && is_wfe_q);
  assign drained = (alignbuf_outstanding_i == '0) && !lsu_busy_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      irq_pkg::ST_RUN: begin
        if (sleep_op != irq_pkg::SLEEP_NONE) begin
          state_d = irq_pkg::ST_DRAIN;
        end
      end
      irq_pkg::ST_DRAIN: begin
        // Wake has priority over entering sleep
        if (wake) begin
          state_d = irq_pkg::ST_RUN;
        end else if (drained) begin
          state_d = irq_pkg::ST_SLEEP;
        end
      end
      irq_pkg::ST_SLEEP: begin
        if (wake) begin
          state_d = irq_pkg::ST_RUN;
        end
      end
      default: state_d = irq_pkg::ST_RUN;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= irq_pkg::ST_RUN;
      is_wfe_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Remember which instruction started this sleep
      if ((state_q == irq_pkg::ST_RUN) && (sleep_op != irq_pkg::SLEEP_NONE)) begin
        is_wfe_q <= (sleep_op == irq_pkg::SLEEP_WFE);
      end
    end
  end

  assign core_sleep_o = (state_q == irq_pkg::ST_SLEEP);

endmodule

`default_nettype wire

// File: hdl/irq_wfi_top.sv
// Top level of the interrupt controller and sleep controller
`timescale 1ns/10ps
`default_nettype none

module irq_wfi_top #(
  parameter int unsigned OUTSTANDING_W = 2
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // Interrupt lines and software control
  input  irq_pkg::irq_vec_t        irq_i,
  input  irq_pkg::csr_wr_t         csr_wr_i,
  input  wire                      mret_i,
  // Writeback and pipeline status
  input  irq_pkg::retire_t         retire_i,
  input  wire [OUTSTANDING_W-1:0]  alignbuf_outstanding_i,
  input  wire                      lsu_busy_i,
  input  wire                      debug_req_i,
  input  wire                      wfe_event_i,
  // Outputs
  output irq_pkg::irq_ack_t        irq_ack_o,
  output irq_pkg::irq_vec_t        mip_o,
  output wire                      mstatus_mie_o,
  output wire                      core_sleep_o
);

  // --------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------
  irq_pkg::irq_vec_t mie;
  logic              take;
  logic              wake_pending;

  irq_pending u_irq_pending (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .irq_i  (irq_i),
    .mip_o  (mip_o)
  );

  irq_csr u_irq_csr (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .csr_wr_i      (csr_wr_i),
    .mret_i        (mret_i),
    .take_i        (take),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie_o)
  );

  irq_prio_arb u_irq_prio_arb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .mip_i          (mip_o),
    .mie_i          (mie),
    .global_en_i    (mstatus_mie_o),
    .take_o         (take),
    .wake_pending_o (wake_pending),
    .irq_ack_o      (irq_ack_o)
  );

  wfi_sleep_ctrl #(
    .OUTSTANDING_W (OUTSTANDING_W)
  ) u_wfi_sleep_ctrl (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .retire_i               (retire_i),
    .alignbuf_outstanding_i (alignbuf_outstanding_i),
    .lsu_busy_i             (lsu_busy_i),
    .wake_pending_i         (wake_pending),
    .debug_req_i            (debug_req_i),
    .wfe_event_i            (wfe_event_i),
    .core_sleep_o           (core_sleep_o)
  );

endmodule

`default_nettype wire

// File: dv/irq_wfi_model.svh
// Cycle model of pending, enables, arbitration and sleep for the testbench
`ifndef IRQ_WFI_MODEL_SVH
`define IRQ_WFI_MODEL_SVH

// ----------------------------------------------------------------------
// Model state, one copy of every visible register
// ----------------------------------------------------------------------
irq_pkg::irq_vec_t     m_mip;
irq_pkg::irq_vec_t     m_mie;
logic                  m_mie_bit;
logic                  m_mpie_bit;
logic                  m_ack;
irq_pkg::irq_id_t      m_ack_id;
irq_pkg::sleep_state_e m_state;
logic                  m_is_wfe;

// Fixed order 31 down to 16, then 11, then 3, then 7
function automatic void pick_winner(input irq_pkg::irq_vec_t pe, output logic found,
                                    output irq_pkg::irq_id_t id);
  found = 1'b0;
  id    = '0;
  for (int i = 31; i >= 16; i--) begin
    if (!found && pe[i]) begin
      found = 1'b1;
      id    = irq_pkg::irq_id_t'(i);
    end
  end
  if (!found && pe[11]) begin
    found = 1'b1;
    id    = 5'd11;
  end
  if (!found && pe[3]) begin
    found = 1'b1;
    id    = 5'd3;
  end
  if (!found && pe[7]) begin
    found = 1'b1;
    id    = 5'd7;
  end
endfunction

task automatic model_reset();
  m_mip      = '0;
  m_mie      = '0;
  m_mie_bit  = 1'b0;
  m_mpie_bit = 1'b0;
  m_ack      = 1'b0;
  m_ack_id   = '0;
  m_state    = irq_pkg::ST_RUN;
  m_is_wfe   = 1'b0;
endtask

// One rising edge, inputs as driven in the cycle before it
task automatic model_step();
  irq_pkg::irq_vec_t pe;
  irq_pkg::irq_id_t  id;
  logic              found;
  logic              take;
  logic              ok;
  logic              op_wfi;
  logic              op_wfe;
  logic              wake;
  logic              drained;
  pe = m_mip & m_mie;
  pick_winner(pe, found, id);
  take    = found && m_mie_bit;
  // A flushed or faulted retire is no sleep op
  ok      = retire.valid && !retire.err && !retire.killed;
  op_wfi  = ok && (retire.rdata == irq_pkg::WFI_INSTR);
  op_wfe  = ok && (retire.rdata == irq_pkg::WFE_INSTR);
  wake    = (pe != '0) || debug_req || (wfe_event && m_is_wfe);
  drained = (outstanding == '0) && !lsu_busy;

  // Sleep FSM, wake checked before drain
  case (m_state)
    irq_pkg::ST_RUN: begin
      if (op_wfi || op_wfe) begin
        m_state  = irq_pkg::ST_DRAIN;
        m_is_wfe = op_wfe;
      end
    end
    irq_pkg::ST_DRAIN: begin
      if (wake) begin
        m_state = irq_pkg::ST_RUN;
      end else if (drained) begin
        m_state = irq_pkg::ST_SLEEP;
      end
    end
    irq_pkg::ST_SLEEP: begin
      if (wake) begin
        m_state = irq_pkg::ST_RUN;
      end
    end
    default: m_state = irq_pkg::ST_RUN;
  endcase

  // Take beats mret, mret beats a software write
  if (take) begin
    m_mpie_bit = m_mie_bit;
    m_mie_bit  = 1'b0;
  end else if (mret) begin
    m_mie_bit  = m_mpie_bit;
    m_mpie_bit = 1'b1;
  end else if (csr_wr.we && (csr_wr.addr == irq_pkg::CSR_MSTATUS)) begin
    m_mie_bit  = csr_wr.data[3];
    m_mpie_bit = csr_wr.data[7];
  end
  if (csr_wr.we && (csr_wr.addr == irq_pkg::CSR_MIE)) begin
    m_mie = csr_wr.data & irq_pkg::VALID_IRQ_MASK;
  end

  m_ack = take;
  if (take) begin
    m_ack_id = id;
  end
  m_mip = irq & irq_pkg::VALID_IRQ_MASK;
endtask

`endif

// File: dv/tb_irq_wfi.sv
// Testbench for the interrupt and sleep controller: clock, reset, random tests, checks
`timescale 1ns/10ps
`default_nettype none

module tb_irq_wfi;

  localparam int OUTSTANDING_W = 2;

  // Test lengths in cycles
  localparam int LEN_PENDING = 300;
  localparam int LEN_PRIO    = 600;
  localparam int LEN_BLOCK   = 200;
  localparam int LEN_SLEEP   = 600;
  localparam int LEN_QUIET   = 400;
  localparam int LEN_WAKE    = 800;
  localparam int TIMEOUT_CYCLES = LEN_PENDING + LEN_PRIO + LEN_BLOCK + LEN_SLEEP
                                + LEN_QUIET + LEN_WAKE + 100;

  logic                     clk_i;
  logic                     rst_ni;
  irq_pkg::irq_vec_t        irq;
  irq_pkg::csr_wr_t         csr_wr;
  logic                     mret;
  irq_pkg::retire_t         retire;
  logic [OUTSTANDING_W-1:0] outstanding;
  logic                     lsu_busy;
  logic                     debug_req;
  logic                     wfe_event;
  irq_pkg::irq_ack_t        irq_ack;
  irq_pkg::irq_vec_t        mip;
  logic                     mstatus_mie;
  logic                     core_sleep;

  int seed;
  int error_count;
  int check_count;
  int test_errors;
  int test_count;
  int cycle_count;

  irq_wfi_top #(
    .OUTSTANDING_W (OUTSTANDING_W)
  ) dut (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .irq_i                  (irq),
    .csr_wr_i               (csr_wr),
    .mret_i                 (mret),
    .retire_i               (retire),
    .alignbuf_outstanding_i (outstanding),
    .lsu_busy_i             (lsu_busy),
    .debug_req_i            (debug_req),
    .wfe_event_i            (wfe_event),
    .irq_ack_o              (irq_ack),
    .mip_o                  (mip),
    .mstatus_mie_o          (mstatus_mie),
    .core_sleep_o           (core_sleep)
  );

  `include "irq_wfi_model.svh"

  // ----------------------------------------------------------------------
  // Clock, model stepping and run limit
  // ----------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Inputs only move on the falling edge, so the model sees stable values
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Checking
  // ----------------------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      test_errors++;
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h, cycle %0d", name, got, exp,
               cycle_count);
    end
  endtask

  // Id is only defined while the ack pulse is high
  task automatic check_outputs();
    compare_value("mip_o", mip, m_mip);
    compare_value("mstatus_mie_o", 32'(mstatus_mie), 32'(m_mie_bit));
    compare_value("irq_ack_o.ack", 32'(irq_ack.ack), 32'(m_ack));
    if (m_ack) begin
      compare_value("irq_ack_o.id", 32'(irq_ack.id), 32'(m_ack_id));
    end
    compare_value("core_sleep_o", 32'(core_sleep), 32'(m_state == irq_pkg::ST_SLEEP));
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  function automatic bit chance(input int pct);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return (r % 100) < pct;
  endfunction

  task automatic drive_idle();
    irq         = '0;
    csr_wr      = '0;
    mret        = 1'b0;
    retire      = '0;
    outstanding = '0;
    lsu_busy    = 1'b0;
    debug_req   = 1'b0;
    wfe_event   = 1'b0;
  endtask

  // Percentages per cycle; sparse words keep several priority levels in play
  task automatic drive_random(input int irq_pct, input bit dense, input int csr_pct,
                              input int mret_pct, input int retire_pct, input int busy_pct,
                              input int wake_pct);
    logic [31:0] word;
    int          pick;
    drive_idle();
    if (chance(irq_pct)) begin
      irq = dense ? $random(seed) : ($random(seed) & $random(seed) & $random(seed));
    end
    if (chance(csr_pct)) begin
      csr_wr.we   = 1'b1;
      csr_wr.addr = chance(50) ? irq_pkg::CSR_MIE : irq_pkg::CSR_MSTATUS;
      csr_wr.data = $random(seed);
      // Bias toward MIE set so acks keep coming
      csr_wr.data[3] = chance(75);
    end
    mret = chance(mret_pct);
    if (chance(retire_pct)) begin
      pick          = ($random(seed) & 32'h7fff_ffff) % 3;
      word          = (pick == 0) ? irq_pkg::WFI_INSTR :
                      (pick == 1) ? irq_pkg::WFE_INSTR : $random(seed);
      retire.valid  = 1'b1;
      retire.rdata  = word;
      retire.err    = chance(15);
      retire.killed = chance(15);
    end
    outstanding = chance(busy_pct) ? OUTSTANDING_W'($random(seed)) : '0;
    lsu_busy    = chance(busy_pct);
    debug_req   = chance(wake_pct);
    wfe_event   = chance(wake_pct * 3);
  endtask

  task automatic write_csr(input irq_pkg::csr_addr_e addr, input logic [31:0] data);
    @(negedge clk_i);
    check_outputs();
    drive_idle();
    csr_wr = '{we: 1'b1, addr: addr, data: data};
  endtask

  task automatic run_test(input string name, input int cycles, input int irq_pct,
                          input bit dense, input int csr_pct, input int mret_pct,
                          input int retire_pct, input int busy_pct, input int wake_pct);
    test_errors = 0;
    repeat (cycles) begin
      @(negedge clk_i);
      check_outputs();
      drive_random(irq_pct, dense, csr_pct, mret_pct, retire_pct, busy_pct, wake_pct);
    end
    test_count++;
    $display("Test %-12s %0d cycles, %0d errors", name, cycles, test_errors);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    seed        = 32'h2654_7bdd;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    cycle_count = 0;
    rst_ni      = 1'b0;
    drive_idle();
    model_reset();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // Dense lines with mie clear, only the pending register moves
    run_test("pending", LEN_PENDING, 100, 1'b1, 0, 0, 0, 0, 0);
    // Random mie, mstatus and mret against sparse lines
    run_test("priority", LEN_PRIO, 60, 1'b0, 20, 15, 0, 0, 0);
    // All lines enabled but MIE and MPIE low, nothing may be acked
    write_csr(irq_pkg::CSR_MIE, 32'hffff_ffff);
    write_csr(irq_pkg::CSR_MSTATUS, 32'h0);
    run_test("mie_blocked", LEN_BLOCK, 100, 1'b1, 0, 0, 0, 0, 0);
    // Sleep entry with a busy pipeline and no pending wake
    write_csr(irq_pkg::CSR_MIE, 32'h0);
    run_test("sleep_busy", LEN_SLEEP, 0, 1'b0, 0, 0, 30, 40, 4);
    // Drained pipeline, sleep two edges after the retire
    run_test("sleep_quiet", LEN_QUIET, 0, 1'b0, 0, 0, 20, 0, 5);
    // All wake sources mixed with sleeps and enable changes
    run_test("wakeup", LEN_WAKE, 10, 1'b0, 5, 5, 30, 20, 5);

    @(negedge clk_i);
    check_outputs();
    $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+dv
hdl/irq_pkg.sv
hdl/irq_pending.sv
hdl/irq_csr.sv
hdl/irq_prio_arb.sv
hdl/wfi_sleep_ctrl.sv
hdl/irq_wfi_top.sv
dv/tb_irq_wfi.sv

// File: run.sh
#!/bin/sh
# Build and run the interrupt and sleep controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_irq_wfi \
  -Mdir obj_dir -o tb_irq_wfi > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Build failed with status $status, see build.log"
  exit 1
fi

./obj_dir/tb_irq_wfi > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
